//--- bench/tb_exp_bf16.sv
`default_nettype none

module tb_exp_bf16
    import exp_pkg::*;
();

    localparam int n_terms   = 6;
    localparam int latency   = n_terms + 3;
    localparam int drain_max = 4 * latency;
    localparam int drop_w    = frac_w - 7;      // fraction bits lost in rounding

    localparam bf16_t edge_in [10] = '{16'h4300, 16'hc300, 16'h42ff, 16'hc2ff, 16'h4301,
                                       16'hc37f, 16'h3aff, 16'h3b00, 16'hbaff, 16'hbb00};

    typedef struct packed
    {
        bf16_t x;
        bf16_t expv;
        int    issue;
    } item_t;

    logic        clk;
    logic        rst;
    logic        valid_i;
    bf16_t       data_i;
    logic        valid_o;
    bf16_t       data_o;

    item_t       exp_q [$];
    int          cyc = 0;
    logic [31:0] lfsr;
    int          sat_hi;
    int          sat_lo;

    exp_bf16_top #(
        .n_terms (n_terms)
    ) i_dut
    (
        .clk     (clk),
        .rst     (rst),
        .valid_i (valid_i),
        .data_i  (data_i),
        .valid_o (valid_o),
        .data_o  (data_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cyc <= cyc + 1;
    end

    //////////////////////////////////////////////////////////////////////
    // reference model and helpers
    //////////////////////////////////////////////////////////////////////

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic bf16_t exp_ref(input bf16_t x);
        longint mag;
        longint t;
        longint n;
        longint f;
        longint r;
        longint acc;
        longint term;
        longint q;
        longint rem;
        longint e;
        int     ex;
        ex = x[14:7];
        if (ex == 255)
            return (x[6:0] != 0) ? bf16_qnan : (x[15] ? bf16_zero : bf16_pinf);
        if (ex < 118)
            return bf16_one;                    // tiny, zero and denormal
        if (ex >= 134)
            return x[15] ? bf16_zero : bf16_pinf;
        mag = longint'(128 + x[6:0]) << (ex - 118);     // lsb weighs 2^-16
        if (x[15])
            mag = -mag;
        t   = (mag * longint'(log2e_fix)) >>> frac_w;
        n   = t >>> frac_w;
        f   = t - (n << frac_w);
        r   = (f * longint'(ln2_fix)) >> frac_w;
        acc = longint'(one_fix);
        for (int k = n_terms; k >= 1; k--)
        begin
            term = (acc * r) >> frac_w;
            term = (term * ((longint'(1) << frac_w) / k)) >> frac_w;
            acc  = longint'(one_fix) + term;
        end
        q   = (acc >> drop_w) & 127;
        rem = acc & ((longint'(1) << drop_w) - 1);
        if (rem > (longint'(1) << (drop_w - 1)) || (rem == (longint'(1) << (drop_w - 1)) && q[0]))
            q = q + 1;                          // nearest, ties to even
        e = 127 + n;
        if (q == 128)
        begin
            q = 0;
            e = e + 1;
        end
        if (e >= 255)
            return bf16_pinf;
        if (e <= 0)
            return bf16_zero;
        return {1'b0, e[7:0], q[6:0]};
    endfunction

    function automatic real bf16_to_real(input bf16_t v);
        real m;
        int  p;
        m = 128.0 + v[6:0];
        p = int'(v[14:7]) - 134;
        while (p > 0)
        begin
            m = m * 2.0;
            p--;
        end
        while (p < 0)
        begin
            m = m / 2.0;
            p++;
        end
        return v[15] ? -m : m;
    endfunction

    task automatic stop_with_failure();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_result(input bf16_t x, input bf16_t got, input bf16_t expv);
        if (got !== expv)
        begin
            $display("** Error at %0t: e^%h gave %h, expected %h", $time, x, got, expv);
            stop_with_failure();
        end
    endtask

    task automatic check_latency(input int got);
        if (got != latency)
        begin
            $display("** Error at %0t: latency %0d, expected %0d", $time, got, latency);
            stop_with_failure();
        end
    endtask

    // model against the real e^x, normal results only
    task automatic check_accuracy(input bf16_t x, input bf16_t y);
        real ideal;
        real ulp;
        real diff;
        ideal = $exp(bf16_to_real(x));
        ulp   = bf16_to_real({1'b0, y[14:7], 7'd0}) / 128.0;
        diff  = bf16_to_real(y) - ideal;
        if (diff < 0.0)
            diff = -diff;
        if (diff > 2.0 * ulp)
        begin
            $display("** Error at %0t: model e^%h = %h is %g ulp off", $time, x, y, diff / ulp);
            stop_with_failure();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic send(input bf16_t x, input bf16_t expv);
        item_t it;
        @(negedge clk);
        valid_i  <= 1'b1;
        data_i   <= x;
        it.x     = x;
        it.expv  = expv;
        it.issue = cyc;
        exp_q.push_back(it);
    endtask

    task automatic idle(input int n);
        for (int i = 0; i < n; i++)
        begin
            @(negedge clk);
            valid_i <= 1'b0;
        end
    endtask

    // |x| in [2^-9, 128), biased exponent 118..133
    task automatic send_random_normal();
        logic [31:0] v;
        bf16_t       x;
        bf16_t       y;
        take_bits(12, v);
        x = {v[11], 8'(118 + v[10:7]), v[6:0]};
        y = exp_ref(x);
        if (y == bf16_pinf)
            sat_hi++;
        else if (y == bf16_zero)
            sat_lo++;
        else
            check_accuracy(x, y);
        send(x, y);
    endtask

    task automatic drain();
        int waited;
        idle(1);
        waited = 0;
        while (exp_q.size() != 0 && waited < drain_max)
        begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0)
        begin
            $display("drain timed out with %0d results still missing", exp_q.size());
            stop_with_failure();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // compare process and main sequence
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk)
    begin : compare
        item_t it;
        if (!rst && valid_o !== 1'b0)
        begin
            if (exp_q.size() == 0)
            begin
                $display("valid_o came out at %0t with no input outstanding", $time);
                stop_with_failure();
            end
            else
            begin
                it = exp_q.pop_front();
                check_latency(cyc - it.issue);
                check_result(it.x, data_o, it.expv);
            end
        end
    end

    initial
    begin : main
        logic [31:0] v;
        rst     = 1'b1;
        valid_i = 1'b0;
        data_i  = '0;
        lfsr    = 32'h406a;
        sat_hi  = 0;
        sat_lo  = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst <= 1'b0;

        for (int i = 0; i < 20; i++)
        begin
            @(negedge clk);
            if (valid_o !== 1'b0)
            begin
                $display("valid_o was not low in the idle cycles after reset");
                stop_with_failure();
            end
        end

        // special inputs with fixed results
        send(16'h0000, bf16_one);
        send(16'h8000, bf16_one);
        send(16'h0001, bf16_one);
        send(16'h807f, bf16_one);
        send(16'h7f80, bf16_pinf);
        send(16'hff80, bf16_zero);
        send(16'h7fc0, bf16_qnan);
        send(16'h7f81, bf16_qnan);      // signaling
        send(16'hffa0, bf16_qnan);
        foreach (edge_in[i])
            send(edge_in[i], exp_ref(edge_in[i]));
        drain();

        repeat (2000) send_random_normal();
        drain();

        // streaming, back to back and then with gaps
        for (int i = 0; i < 64; i++)
        begin
            take_bits(16, v);
            send(v[15:0], exp_ref(v[15:0]));
        end
        for (int i = 0; i < 200; i++)
        begin
            take_bits(2, v);
            idle(v[1:0]);
            take_bits(16, v);
            send(v[15:0], exp_ref(v[15:0]));
        end
        drain();

        if (sat_hi == 0 || sat_lo == 0)
        begin
            $display("random inputs never reached the overflow or the flush to zero");
            stop_with_failure();
        end
        else
        begin
            $display("No errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- flist.f
src/exp_pkg.sv
src/exp_stage_if.sv
src/exp_range_reduce.sv
src/exp_horner_stage.sv
src/exp_result_pack.sv
src/exp_bf16_top.sv
bench/tb_exp_bf16.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the bfloat16 exp testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_exp_bf16 -f flist.f -o tb_exp_bf16 > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_exp_bf16 > sim.log 2>&1
cat sim.log

grep -qx "No errors" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- src/exp_bf16_top.sv
`default_nettype none

// e^x for bfloat16, fully pipelined, latency n_terms+3
module exp_bf16_top
    import exp_pkg::*;
#(
    parameter int n_terms = 6
)
(
    input  logic  clk,
    input  logic  rst,
    input  logic  valid_i,
    input  bf16_t data_i,
    output logic  valid_o,
    output bf16_t data_o
);

    // link 0 from the reducer, link n_terms into the packer
    exp_stage_if links [0:n_terms] ();

    //////////////////////////////////////////////////////////////////////
    // range reduction
    //////////////////////////////////////////////////////////////////////

    exp_range_reduce i_reduce
    (
        .clk     (clk),
        .rst     (rst),
        .valid_i (valid_i),
        .data_i  (data_i),
        .out     (links[0])
    );

    //////////////////////////////////////////////////////////////////////
    // Horner chain, highest term first
    //////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < n_terms; i++)
    begin : g_stage
        exp_horner_stage #(
            .k (n_terms - i)
        ) i_stage
        (
            .clk (clk),
            .rst (rst),
            .up  (links[i]),
            .dn  (links[i+1])
        );
    end

    //////////////////////////////////////////////////////////////////////
    // output
    //////////////////////////////////////////////////////////////////////

    exp_result_pack i_pack
    (
        .clk     (clk),
        .rst     (rst),
        .in      (links[n_terms]),
        .valid_o (valid_o),
        .data_o  (data_o)
    );

endmodule

`default_nettype wire

//--- src/exp_horner_stage.sv
`default_nettype none

// acc <= 1 + acc * r / k
module exp_horner_stage
    import exp_pkg::*;
#(
    parameter int k = 1
)
(
    input  logic      clk,
    input  logic      rst,
    exp_stage_if.dst  up,
    exp_stage_if.src  dn
);

    localparam unit_t inv_c = inv_k(k);

    logic [2*$bits(unit_t)-1:0] prod_ar;
    unit_t                      term_ar;
    logic [2*$bits(unit_t)-1:0] prod_k;
    unit_t                      term;
    logic [$bits(unit_t):0]     acc_sum;    // one spare bit to catch overflow

    // two truncating steps, first by r then by 1/k
    assign prod_ar = up.acc * up.r;
    assign term_ar = unit_t'(prod_ar >> frac_w);
    assign prod_k  = term_ar * inv_c;
    assign term    = unit_t'(prod_k >> frac_w);
    assign acc_sum = one_fix + term;

    always_ff @(posedge clk)
    begin
        if (rst)
            dn.valid <= 1'b0;
        else
            dn.valid <= up.valid;
    end

    always_ff @(posedge clk)
    begin
        dn.bypass     <= up.bypass;
        dn.bypass_val <= up.bypass_val;
        dn.shift      <= up.shift;
        dn.r          <= up.r;
        dn.acc        <= acc_sum[$bits(unit_t)-1:0];
    end

    // r < ln 2 keeps every partial sum of e^r below 2.0
    a_acc_below_two: assert property (
        @(posedge clk) disable iff (rst)
        (up.valid && !up.bypass) |-> (acc_sum < 2 * one_fix)
    ) else $error("horner stage %0d: accumulator reached 2.0", k);

endmodule

`default_nettype wire

//--- src/exp_pkg.sv
`default_nettype none

package exp_pkg;

    //////////////////////////////////////////////////////////////////////
    // bfloat16 format
    //////////////////////////////////////////////////////////////////////

    typedef logic [15:0] bf16_t;

    localparam int bf16_man_w = 7;       // stored fraction bits
    localparam int bf16_bias  = 127;

    // biased exponent window that goes through the datapath
    localparam logic [7:0] exp_tiny = 8'd118;   // below: |x| < 2^-9, result 1.0
    localparam logic [7:0] exp_huge = 8'd134;   // at or above: |x| >= 128, saturate

    localparam bf16_t bf16_one  = 16'h3f80;
    localparam bf16_t bf16_pinf = 16'h7f80;
    localparam bf16_t bf16_qnan = 16'h7fc0;
    localparam bf16_t bf16_zero = 16'h0000;

    //////////////////////////////////////////////////////////////////////
    // fixed point
    //////////////////////////////////////////////////////////////////////

    localparam int frac_w = 16;

    // x in two's complement, 8 integer bits incl. sign
    typedef logic signed [7+frac_w:0] fix_t;

    // r and the polynomial accumulator, range [0,2)
    typedef logic [frac_w:0] unit_t;

    // integer part n of x*log2(e)
    typedef logic signed [9:0] shift_t;

    localparam unit_t log2e_fix = 17'h17154;    // 1.442695 * 2^16
    localparam unit_t ln2_fix   = 17'h0b172;    // 0.693147 * 2^16
    localparam unit_t one_fix   = 17'h10000;

    // reciprocal of the Taylor term index, scaled by 2^16
    function automatic unit_t inv_k(input int unsigned k);
        logic [31:0] q;
        q = (32'd1 << frac_w) / k;
        return unit_t'(q);
    endfunction

endpackage

`default_nettype wire

//--- src/exp_range_reduce.sv
`default_nettype none

module exp_range_reduce
    import exp_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       valid_i,
    input  bf16_t      data_i,
    exp_stage_if.src   out
);

    // t needs one bit more than x, |x*log2(e)| reaches 185
    localparam int t_w = $bits(fix_t) + 1;

    logic                          sgn;
    logic [7:0]                    exp_b;
    logic [bf16_man_w-1:0]         man;
    logic [7:0]                    sh;
    logic [$bits(fix_t)-2:0]       x_mag;
    fix_t                          x_fix;
    logic signed [$bits(fix_t)+17:0] prod;
    logic signed [t_w-1:0]         t_c;

    logic                          byp_c;
    bf16_t                         bval_c;

    // stage 1 registers
    logic                          v1;
    logic                          byp1;
    bf16_t                         bval1;
    logic signed [t_w-1:0]         t1;

    // stage 2 combinational
    shift_t                        n_c;
    logic [frac_w-1:0]             f_c;
    logic [frac_w+$bits(unit_t)-1:0] r_prod;

    assign sgn   = data_i[15];
    assign exp_b = data_i[14:bf16_man_w];
    assign man   = data_i[bf16_man_w-1:0];

    //////////////////////////////////////////////////////////////////////
    // cycle 1: classify and convert
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        byp_c  = 1'b1;
        bval_c = bf16_one;
        if (exp_b == 8'hff)
        begin
            if (man != '0)
                bval_c = bf16_qnan;     // any NaN comes out quiet
            else
                bval_c = sgn ? bf16_zero : bf16_pinf;
        end
        else if (exp_b < exp_tiny)
            bval_c = bf16_one;          // also zero and denormals
        else if (exp_b >= exp_huge)
            bval_c = sgn ? bf16_zero : bf16_pinf;
        else
            byp_c = 1'b0;
    end

    // exact conversion, the lsb of x_fix weighs 2^-16
    assign sh    = exp_b - exp_tiny;
    assign x_mag = {15'b0, 1'b1, man} << sh[3:0];
    assign x_fix = sgn ? -fix_t'({1'b0, x_mag}) : fix_t'({1'b0, x_mag});

    assign prod = x_fix * $signed({1'b0, log2e_fix});
    assign t_c  = prod[frac_w +: t_w];          // arithmetic >> frac_w

    always_ff @(posedge clk)
    begin
        if (rst)
            v1 <= 1'b0;
        else
            v1 <= valid_i;
    end

    always_ff @(posedge clk)
    begin
        byp1  <= byp_c;
        bval1 <= bval_c;
        t1    <= t_c;
    end

    //////////////////////////////////////////////////////////////////////
    // cycle 2: split into n and f, rescale f by ln 2
    //////////////////////////////////////////////////////////////////////

    assign n_c    = shift_t'(t1 >>> frac_w);    // floor, also for negative t
    assign f_c    = t1[frac_w-1:0];
    assign r_prod = f_c * ln2_fix;

    always_ff @(posedge clk)
    begin
        if (rst)
            out.valid <= 1'b0;
        else
            out.valid <= v1;
    end

    always_ff @(posedge clk)
    begin
        out.bypass     <= byp1;
        out.bypass_val <= bval1;
        out.shift      <= n_c;
        out.r          <= unit_t'(r_prod >> frac_w);
        out.acc        <= one_fix;      // Horner starts from 1
    end

    // the input window bounds n, so the packer only saturates on the exponent
    a_shift_range: assert property (
        @(posedge clk) disable iff (rst)
        (out.valid && !out.bypass) |-> (out.shift >= -185 && out.shift <= 185)
    ) else $error("range reduce: shift out of range");

endmodule

`default_nettype wire

//--- src/exp_result_pack.sv
`default_nettype none

module exp_result_pack
    import exp_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    exp_stage_if.dst   in,
    output logic       valid_o,
    output bf16_t      data_o
);

    localparam int drop_w = frac_w - bf16_man_w;    // fraction bits rounded away

    logic [bf16_man_w-1:0]   keep;
    logic                    lsb;
    logic                    guard;
    logic                    sticky;
    logic                    rnd_up;
    logic [bf16_man_w:0]     frac_rnd;
    logic                    carry;
    logic signed [10:0]      shift_ext;
    logic signed [10:0]      exp_sum;
    bf16_t                   res_c;

    //////////////////////////////////////////////////////////////////////
    // round to nearest even
    //////////////////////////////////////////////////////////////////////

    // acc is 1.xxxx, the leading one is implied in the output
    assign keep   = in.acc[frac_w-1:drop_w];
    assign lsb    = in.acc[drop_w];
    assign guard  = in.acc[drop_w-1];
    assign sticky = |in.acc[drop_w-2:0];
    assign rnd_up = guard & (sticky | lsb);

    assign frac_rnd = {1'b0, keep} + {{bf16_man_w{1'b0}}, rnd_up};
    assign carry    = frac_rnd[bf16_man_w];     // 1.1111111 rounded up to 10.0

    //////////////////////////////////////////////////////////////////////
    // exponent and saturation
    //////////////////////////////////////////////////////////////////////

    assign shift_ext = in.shift;
    assign exp_sum   = shift_ext + 11'(bf16_bias) + $signed({10'b0, carry});

    always_comb
    begin
        if (in.bypass)
            res_c = in.bypass_val;
        else if (exp_sum >= 255)
            res_c = bf16_pinf;
        else if (exp_sum <= 0)
            res_c = bf16_zero;      // no denormal outputs
        else
            res_c = {1'b0, exp_sum[7:0], frac_rnd[bf16_man_w-1:0]};
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            valid_o <= 1'b0;
        else
            valid_o <= in.valid;
    end

    always_ff @(posedge clk)
    begin
        data_o <= res_c;
    end

    // the whole valid chain starts cleared, so no X may leak out
    a_valid_known: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(valid_o)
    ) else $error("result pack: valid_o unknown");

endmodule

`default_nettype wire

//--- src/exp_stage_if.sv
`default_nettype none

// one item in flight between two pipeline stages
interface exp_stage_if
    import exp_pkg::*;
();

    logic   valid;        // item strobe
    logic   bypass;       // result already known, datapath ignored
    bf16_t  bypass_val;
    shift_t shift;        // n, applied to the exponent at the end
    unit_t  r;            // reduced argument f*ln2
    unit_t  acc;          // Horner accumulator

    modport src
    (
        output valid, bypass, bypass_val, shift, r, acc
    );

    modport dst
    (
        input valid, bypass, bypass_val, shift, r, acc
    );

endinterface

`default_nettype wire
